/* include/uart_params.svh */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Serial bit period in clk cycles, must be even
`define UART_CLKS_PER_BIT 16

// Width of the baud tick counter
`define UART_BAUD_CNT_W 8

// Byte FIFO entries, power of two
`define UART_FIFO_DEPTH 8

// Width of the good character counter
`define UART_COUNT_W 8

`endif

/* logic/uart_pkg.sv */
package uart_pkg;

  `include "uart_params.svh"

  typedef logic [7:0] byte_t;                   // One serial data byte
  typedef logic [`UART_COUNT_W-1:0] count_t;    // Good characters received

  // Receiver FSM
  typedef enum logic [2:0] {
    RX_IDLE,   // Line idle, tick generator held
    RX_START,  // Waiting for mid start bit
    RX_DATA,   // Shifting in eight data bits
    RX_STOP,   // Waiting for mid stop bit
    RX_DONE    // Good byte strobe
  } rx_state_t;

  // Transmitter FSM
  typedef enum logic [2:0] {
    TX_IDLE,   // Line high, waiting for data and cts
    TX_LOAD,   // Byte latched, release tick generator
    TX_START,  // Half bit lead-in, then start bit
    TX_DATA,   // Eight data bits, LSB first
    TX_STOP    // Stop bit
  } tx_state_t;

endpackage

/* logic/baud_tick_gen.sv */
`timescale 1ns/100ps
`include "uart_params.svh"

module baud_tick_gen (
  input  logic clk,
  input  logic rstn,
  input  logic restart,  // Hold counter at zero
  output logic tick      // One cycle clock enable
);

  localparam int CNT_W = `UART_BAUD_CNT_W;
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);

  logic [CNT_W-1:0] cnt;
  logic             first;  // Still waiting for the half period tick
  logic [CNT_W-1:0] last;

  assign last = first ? HALF_LAST : FULL_LAST;
  assign tick = !restart && (cnt == last);

  // Half period first so the receiver samples at bit centres
  always_ff @(posedge clk) begin
    if (!rstn || restart) begin
      cnt   <= '0;
      first <= 1'b1;
    end else if (tick) begin
      cnt   <= '0;   // Wrap and switch to full periods
      first <= 1'b0;
    end else begin
      cnt   <= cnt + 1'b1;
    end
  end

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
  input  logic             clk,
  input  logic             rstn,
  input  logic             rx,            // Serial line in
  input  logic             baud_tick,     // Mid bit sample enable
  output logic             baud_restart,  // Holds tick generator
  output logic             rx_strobe,     // One cycle per good byte
  output uart_pkg::byte_t  rx_data,       // Last good byte
  output uart_pkg::count_t rx_count,      // Good bytes so far
  output logic             frame_error    // Sticky, bad stop bit seen
);

  import uart_pkg::*;

  rx_state_t  state;
  logic       rx_meta;     // First synchroniser stage
  logic       rx_sync;     // Safe copy of rx
  logic       rx_prev;     // For falling edge detect
  logic       start_edge;
  byte_t      shifter;
  logic [2:0] bit_cnt;

  // Two flop synchroniser, idles high
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // Edge, not level, so a low line after a bad stop bit is not a new start
  assign start_edge = rx_prev && !rx_sync;

  assign baud_restart = (state == RX_IDLE) || (state == RX_DONE);
  assign rx_strobe    = (state == RX_DONE);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= RX_IDLE;
      bit_cnt     <= '0;
      rx_count    <= '0;
      frame_error <= 1'b0;
    end else begin
      case (state)
        RX_IDLE:
          if (start_edge) state <= RX_START;
        RX_START:
          if (baud_tick) begin
            // Line back high at mid start bit, was only a glitch
            state   <= rx_sync ? RX_IDLE : RX_DATA;
            bit_cnt <= '0;
          end
        RX_DATA:
          if (baud_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= RX_STOP;  // Eighth bit taken
          end
        RX_STOP:
          if (baud_tick) begin
            if (rx_sync) begin
              state    <= RX_DONE;
              rx_count <= rx_count + 1'b1;  // Visible with the strobe
            end else begin
              state       <= RX_IDLE;       // Drop the frame
              frame_error <= 1'b1;
            end
          end
        RX_DONE:
          state <= RX_IDLE;
        default:
          state <= RX_IDLE;
      endcase
    end
  end

  // Shift register and data register
  always_ff @(posedge clk) begin
    if (state == RX_DATA && baud_tick)
      shifter <= {rx_sync, shifter[7:1]};   // LSB arrives first
    if (state == RX_STOP && baud_tick && rx_sync)
      rx_data <= shifter;                   // Ready in the strobe cycle
  end

  a_strobe_one_cycle: assert property (
    @(posedge clk) disable iff (!rstn) rx_strobe |=> !rx_strobe);

  // While idle the held generator must stay silent
  a_idle_no_tick: assert property (
    @(posedge clk) disable iff (!rstn)
    (state == RX_IDLE) |-> !baud_tick);

endmodule

/* logic/byte_fifo.sv */
`timescale 1ns/100ps
`include "uart_params.svh"

module byte_fifo (
  input  logic            clk,
  input  logic            rstn,
  input  logic            push,      // Write strobe
  input  logic            pop,       // Read strobe, head advances
  input  uart_pkg::byte_t wr_data,
  output uart_pkg::byte_t rd_data,   // Head entry, valid when not empty
  output logic            empty,
  output logic            full,
  output logic            overflow   // Sticky, byte lost on full
);

  import uart_pkg::*;

  localparam int DEPTH = `UART_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  byte_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   occ;      // Entries in use, one bit wider than pointers
  logic             do_push;

  assign do_push = push && !full;
  assign empty   = (occ == '0);
  assign full    = (occ == (PTR_W+1)'(DEPTH));
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wr_data;
  end

  // Pointers wrap naturally at power of two depth
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      occ      <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)     rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, pop})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;          // Both or neither
      endcase
      if (push && full) overflow <= 1'b1;
    end
  end

  // Consumer must look at empty before popping
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rstn) pop |-> !empty);

  // Counter and pointers agree on the fill level
  a_occ_matches_ptrs: assert property (
    @(posedge clk) disable iff (!rstn)
    occ[PTR_W-1:0] == PTR_W'(wr_ptr - rd_ptr));

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx (
  input  logic            clk,
  input  logic            rstn,
  input  logic            cts,           // Clear to send level
  input  logic            empty,         // FIFO has no data
  input  uart_pkg::byte_t rd_data,       // FIFO head
  output logic            pop,           // Take head byte
  input  logic            baud_tick,
  output logic            baud_restart,
  output logic            tx             // Serial line out
);

  import uart_pkg::*;

  tx_state_t  state;
  byte_t      shifter;
  logic [2:0] bit_cnt;
  logic       stop_out;  // Stop level already on the line

  assign pop          = (state == TX_IDLE) && cts && !empty;
  assign baud_restart = (state == TX_IDLE) || (state == TX_LOAD);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= TX_IDLE;
      bit_cnt  <= '0;
      stop_out <= 1'b0;
      tx       <= 1'b1;     // Line idles high
    end else begin
      case (state)
        TX_IDLE:
          if (pop) state <= TX_LOAD;
        TX_LOAD:
          state <= TX_START;  // Generator released from here on
        TX_START:
          // Half bit tick only marks the start of the start bit
          if (baud_tick) begin
            tx      <= 1'b0;
            bit_cnt <= '0;
            state   <= TX_DATA;
          end
        TX_DATA:
          if (baud_tick) begin
            tx      <= shifter[0];
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state    <= TX_STOP;
              stop_out <= 1'b0;
            end
          end
        TX_STOP:
          if (baud_tick) begin
            if (!stop_out) begin
              tx       <= 1'b1;   // Stop bit begins
              stop_out <= 1'b1;
            end else begin
              state <= TX_IDLE;   // Full stop bit done
            end
          end
        default:
          state <= TX_IDLE;
      endcase
    end
  end

  // Byte latch and shift
  always_ff @(posedge clk) begin
    if (pop)
      shifter <= rd_data;
    else if (state == TX_DATA && baud_tick)
      shifter <= {1'b0, shifter[7:1]};
  end

  // Line must be back high whenever no frame is in progress
  a_idle_line_high: assert property (
    @(posedge clk) disable iff (!rstn)
    (state == TX_IDLE) |-> tx);

endmodule

/* logic/uart_echo_top.sv */
`timescale 1ns/100ps

module uart_echo_top (
  input  logic             clk,
  input  logic             rstn,
  input  logic             rx,
  input  logic             cts,
  output logic             tx,
  output uart_pkg::byte_t  rx_data,
  output uart_pkg::count_t rx_count,
  output logic             frame_error,
  output logic             overflow
);

  import uart_pkg::*;

  logic  rx_baud_tick;
  logic  rx_baud_restart;
  logic  rx_strobe;
  logic  tx_baud_tick;
  logic  tx_baud_restart;
  logic  tx_pop;
  logic  fifo_empty;
  byte_t fifo_rd_data;

  baud_tick_gen rx_baud_i (
    .clk(clk), .rstn(rstn), .restart(rx_baud_restart), .tick(rx_baud_tick));

  uart_rx uart_rx_i (
    .clk(clk), .rstn(rstn), .rx(rx),
    .baud_tick(rx_baud_tick), .baud_restart(rx_baud_restart),
    .rx_strobe(rx_strobe), .rx_data(rx_data), .rx_count(rx_count),
    .frame_error(frame_error));

  // Full only matters inside the FIFO, dropped bytes show as overflow
  byte_fifo byte_fifo_i (
    .clk(clk), .rstn(rstn), .push(rx_strobe), .pop(tx_pop),
    .wr_data(rx_data), .rd_data(fifo_rd_data),
    .empty(fifo_empty), .full(), .overflow(overflow));

  baud_tick_gen tx_baud_i (
    .clk(clk), .rstn(rstn), .restart(tx_baud_restart), .tick(tx_baud_tick));

  uart_tx uart_tx_i (
    .clk(clk), .rstn(rstn), .cts(cts),
    .empty(fifo_empty), .rd_data(fifo_rd_data), .pop(tx_pop),
    .baud_tick(tx_baud_tick), .baud_restart(tx_baud_restart),
    .tx(tx));

endmodule

/* sim/tb_uart_echo.sv */
`timescale 1ns/100ps
`include "uart_params.svh"

module tb_uart_echo;

  import uart_pkg::*;

  localparam int BIT        = `UART_CLKS_PER_BIT;
  localparam int FRAME      = 10 * BIT;       // Start, eight data, stop
  localparam int RX_TIMEOUT = 4 * FRAME;      // Longest wait for a tx start bit
  localparam int DEPTH      = `UART_FIFO_DEPTH;

  logic   clk, rstn, rx, cts;
  logic   tx, frame_error, overflow;
  byte_t  rx_data;
  count_t rx_count;

  logic [31:0] lcg_state = 32'h4801f4d6;
  count_t      exp_count;  // Model of the good character counter
  byte_t       exp_data;   // Model of the last good byte
  int          errors;
  int          tests_ok;
  int          tests_bad;

  uart_echo_top uart_echo_top_i (
    .clk(clk), .rstn(rstn), .rx(rx), .cts(cts), .tx(tx), .rx_data(rx_data),
    .rx_count(rx_count), .frame_error(frame_error), .overflow(overflow));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz
  end

  // Hang guard for the whole run
  initial begin
    repeat (200000) @(posedge clk);
    $display("Watchdog expired, the simulation did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  function automatic byte_t rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];  // Upper bits have the longer period
  endfunction

  task automatic check_eq(input string test, input string what,
                          input logic [7:0] expected, input logic [7:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s: %s expected %h, got %h", test, what, expected, actual);
      errors++;
    end
  endtask

  // One 8N1 frame on rx, stop bit optionally low
  task automatic send_byte(input byte_t data, input bit bad_stop);
    @(negedge clk);
    rx = 1'b0;
    repeat (BIT) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rx = data[i];                   // LSB first
      repeat (BIT) @(negedge clk);
    end
    rx = !bad_stop;
    repeat (BIT) @(negedge clk);
    rx = 1'b1;
  endtask

  // Decode one frame from tx, sampled near bit centres
  task automatic recv_byte(input string test, output byte_t data, output bit ok);
    int waited;
    waited = 0;
    data   = '0;
    ok     = 1'b0;
    @(negedge clk);
    while (tx !== 1'b0 && waited < RX_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    assert (tx === 1'b0) else begin
      $display("%s: no start bit on tx within %0d cycles", test, RX_TIMEOUT);
      errors++;
    end
    if (tx === 1'b0) begin
      repeat (BIT/2) @(negedge clk);  // Centre of start bit
      for (int i = 0; i < 8; i++) begin
        repeat (BIT) @(negedge clk);
        data[i] = tx;
      end
      repeat (BIT) @(negedge clk);    // Centre of stop bit
      ok = (tx === 1'b1);
      assert (ok) else begin
        $display("%s: stop bit on tx was low", test);
        errors++;
      end
    end
  endtask

  task automatic expect_tx_idle(input string test, input int cycles);
    bit quiet;
    quiet = 1'b1;
    for (int i = 0; i < cycles && quiet; i++) begin
      @(negedge clk);
      quiet = (tx === 1'b1);
    end
    assert (quiet) else begin
      $display("%s: tx left idle although nothing was due for echo", test);
      errors++;
    end
  endtask

  task automatic report_test(input string test, input int errors_before);
    if (errors == errors_before) begin
      $display("%s: ok", test);
      tests_ok++;
    end else begin
      $display("%s: %0d errors", test, errors - errors_before);
      tests_bad++;
    end
  endtask

  // Good byte out on rx, same byte expected back on tx
  task automatic echo_one(input string test, input byte_t data);
    byte_t got;
    bit    ok;
    fork
      send_byte(data, 1'b0);
      recv_byte(test, got, ok);
    join
    exp_count = exp_count + 1'b1;
    exp_data  = data;
    if (ok) check_eq(test, "echoed byte", data, got);
  endtask

  task automatic test_single_echo();
    string t = "test_single_echo";
    byte_t b;
    int    e0;
    e0 = errors;
    check_eq(t, "tx after reset", 8'd1, 8'(tx));
    check_eq(t, "rx_count after reset", 8'd0, rx_count);
    b = rand_byte();
    echo_one(t, b);
    check_eq(t, "rx_data", b, rx_data);
    check_eq(t, "rx_count", 8'd1, rx_count);
    report_test(t, e0);
  endtask

  task automatic test_burst_order();
    string t = "test_burst_order";
    byte_t burst [20];
    byte_t exp_q [$];  // Scoreboard, oldest first
    byte_t got;
    bit    ok;
    int    e0;
    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      burst[i] = rand_byte();
      exp_q.push_back(burst[i]);
    end
    fork
      begin
        for (int i = 0; i < 20; i++) send_byte(burst[i], 1'b0);
      end
      begin
        for (int i = 0; i < 20; i++) begin
          recv_byte(t, got, ok);
          if (!ok) break;
          check_eq(t, "echoed byte", exp_q.pop_front(), got);
        end
      end
    join
    exp_count = exp_count + count_t'(20);
    exp_data  = burst[19];
    check_eq(t, "rx_count", exp_count, rx_count);
    report_test(t, e0);
  endtask

  task automatic test_overflow();
    string t = "test_overflow";
    byte_t exp_q [$];
    byte_t b;
    byte_t got;
    bit    ok;
    int    e0;
    e0 = errors;
    check_eq(t, "overflow before", 8'd0, 8'(overflow));
    @(negedge clk);
    cts = 1'b0;                           // Transmitter parked, FIFO fills
    for (int i = 0; i < 10; i++) begin
      b = rand_byte();
      send_byte(b, 1'b0);
      exp_count = exp_count + 1'b1;       // Counted even when dropped
      exp_data  = b;
      if (i < DEPTH) exp_q.push_back(b);  // Later ones find the FIFO full
    end
    repeat (4) @(negedge clk);
    check_eq(t, "overflow", 8'd1, 8'(overflow));
    check_eq(t, "rx_count", exp_count, rx_count);
    cts = 1'b1;
    for (int i = 0; i < DEPTH; i++) begin
      recv_byte(t, got, ok);
      if (!ok) break;
      check_eq(t, "echoed byte", exp_q.pop_front(), got);
    end
    expect_tx_idle(t, 2 * FRAME);         // Dropped bytes never show up
    report_test(t, e0);
  endtask

  task automatic test_frame_error();
    string t = "test_frame_error";
    int    e0;
    e0 = errors;
    check_eq(t, "frame_error before", 8'd0, 8'(frame_error));
    send_byte(~exp_data, 1'b1);           // Differs from the held byte
    repeat (2) @(negedge clk);
    check_eq(t, "frame_error", 8'd1, 8'(frame_error));
    check_eq(t, "rx_count", exp_count, rx_count);
    check_eq(t, "rx_data", exp_data, rx_data);
    expect_tx_idle(t, 2 * FRAME);
    report_test(t, e0);
  endtask

  task automatic test_glitch_reject();
    string t = "test_glitch_reject";
    int    e0;
    e0 = errors;
    @(negedge clk);
    rx = 1'b0;
    repeat (BIT/4 - 1) @(negedge clk);    // Under a quarter bit
    rx = 1'b1;
    expect_tx_idle(t, 2 * FRAME);
    check_eq(t, "rx_count after glitch", exp_count, rx_count);
    echo_one(t, rand_byte());             // Receiver must still lock on
    check_eq(t, "rx_count", exp_count, rx_count);
    check_eq(t, "rx_data", exp_data, rx_data);
    report_test(t, e0);
  endtask

  initial begin
    rstn      = 1'b0;
    rx        = 1'b1;                     // Line idles high
    cts       = 1'b1;
    exp_count = '0;
    exp_data  = '0;
    errors    = 0;
    tests_ok  = 0;
    tests_bad = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    repeat (4) @(negedge clk);
    test_single_echo();
    test_burst_order();
    test_overflow();
    test_frame_error();
    test_glitch_reject();
    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
logic/uart_pkg.sv
logic/baud_tick_gen.sv
logic/uart_rx.sv
logic/byte_fifo.sv
logic/uart_tx.sv
logic/uart_echo_top.sv
sim/tb_uart_echo.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module tb_uart_echo
	./obj_dir/Vtb_uart_echo | tee sim.log
	grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log
